// ==== logic/mlpPkg.sv ====
package mlpPkg;

	// --------------------------------------------------
	// network sizes and fixed-point format
	// --------------------------------------------------
	localparam int numInputs = 15;
	localparam int numHidden = 8;
	localparam int numOutputs = 4;
	localparam int maxFanIn = 15;
	localparam int fracBits = 8;

	localparam int layerLatency = 3; // input, sum and relu registers.
	localparam int netLatency = 2 * layerLatency;

	typedef logic signed [15:0] fixWord; // Q8.8 two's complement.
	typedef logic [7:0] apbAddr;
	typedef logic [31:0] apbData;

	typedef fixWord [0:maxFanIn-1] fanInVec; // lane k holds input k.
	typedef fixWord [0:numInputs-1] inputVec;
	typedef fixWord [0:numHidden-1] hiddenVec;
	typedef fixWord [0:numOutputs-1] outputVec;

	typedef enum logic [1:0] {idle, running, finished} ctrlState;

	typedef struct packed {
		logic psel;
		logic penable;
		logic pwrite;
		apbAddr paddr;
		apbData pwdata;
	} apbReq;

	typedef struct packed {
		apbData prdata;
		logic pready;
		logic pslverr;
	} apbRsp;

	// --------------------------------------------------
	// register map
	// --------------------------------------------------
	localparam apbAddr addrInputBase = 8'h00;
	localparam apbAddr addrCtrl = 8'h40;
	localparam apbAddr addrStatus = 8'h44;
	localparam apbAddr addrOutputBase = 8'h50;

	// --------------------------------------------------
	// fixed weights, raw Q8.8 values
	// --------------------------------------------------
	localparam fanInVec hiddenWeights [numHidden] = '{
		'{16'sd212, -16'sd87, 16'sd340, -16'sd512, 16'sd96, 16'sd18, -16'sd230, 16'sd410,
			-16'sd66, 16'sd155, -16'sd301, 16'sd73, 16'sd260, -16'sd140, 16'sd35},
		'{-16'sd180, 16'sd402, -16'sd25, 16'sd133, -16'sd377, 16'sd288, 16'sd61, -16'sd94,
			16'sd517, -16'sd210, 16'sd44, -16'sd158, 16'sd90, 16'sd323, -16'sd269},
		'{16'sd75, -16'sd148, 16'sd606, -16'sd33, 16'sd210, -16'sd420, 16'sd117, 16'sd39,
			-16'sd286, 16'sd364, 16'sd182, -16'sd71, -16'sd455, 16'sd58, 16'sd241},
		'{-16'sd310, 16'sd27, -16'sd96, 16'sd450, 16'sd168, -16'sd55, 16'sd392, -16'sd237,
			16'sd84, -16'sd19, 16'sd276, 16'sd530, -16'sd122, -16'sd348, 16'sd106},
		'{16'sd1480, -16'sd1320, 16'sd905, -16'sd760, 16'sd1210, -16'sd1105, 16'sd640,
			-16'sd980, 16'sd1350, -16'sd870, 16'sd725, -16'sd1190, 16'sd1020, -16'sd655,
			16'sd1275},
		'{16'sd48, 16'sd295, -16'sd163, -16'sd84, 16'sd371, 16'sd126, -16'sd442, 16'sd209,
			-16'sd57, 16'sd88, -16'sd316, 16'sd240, 16'sd14, 16'sd187, -16'sd99},
		'{-16'sd265, -16'sd131, 16'sd78, 16'sd356, -16'sd42, 16'sd198, 16'sd251, -16'sd389,
			16'sd143, 16'sd67, -16'sd203, -16'sd28, 16'sd415, -16'sd176, 16'sd322},
		'{16'sd150, -16'sd441, 16'sd597, 16'sd204, -16'sd222, -16'sd155, -16'sd463, 16'sd50,
			16'sd118, -16'sd352, -16'sd15, 16'sd381, 16'sd792, -16'sd61, -16'sd114}
	};

	localparam hiddenVec hiddenBias = '{16'sd64, -16'sd32, 16'sd120, -16'sd90, 16'sd256,
		16'sd15, -16'sd128, -16'sd51};

	localparam hiddenVec outWeights [numOutputs] = '{
		'{16'sd310, -16'sd145, 16'sd228, -16'sd96, 16'sd402, 16'sd57, -16'sd260, 16'sd183},
		'{-16'sd120, 16'sd276, -16'sd51, 16'sd345, 16'sd90, -16'sd210, 16'sd418, -16'sd33},
		'{16'sd1550, -16'sd1400, 16'sd1290, 16'sd1170, -16'sd1380, 16'sd960, -16'sd1240,
			16'sd1305},
		'{16'sd64, 16'sd197, -16'sd318, 16'sd142, -16'sd75, 16'sd289, 16'sd36, -16'sd204}
	};

	localparam outputVec outBias = '{16'sd40, -16'sd25, 16'sd100, 16'sd12};

endpackage

// ==== logic/neuronNode.sv ====
`timescale 1ns/1ps

module neuronNode #(
	parameter int fanIn = mlpPkg::maxFanIn
) (
	input logic clk,
	input logic reset,
	input mlpPkg::fanInVec act,
	input mlpPkg::fanInVec weights,
	input mlpPkg::fixWord bias,
	output mlpPkg::fixWord result
);
	import mlpPkg::*;

	fixWord [0:fanIn-1] actReg;
	fixWord sumReg;
	fixWord weightedSum;

	// --------------------------------------------------
	// multiply-accumulate on the registered inputs
	// --------------------------------------------------
	always_comb
	begin
		logic signed [31:0] product;
		weightedSum = bias;
		for (int i = 0; i < fanIn; i++)
		begin
			product = $signed(actReg[i]) * $signed(weights[i]); // full Q16.16 product.
			weightedSum = weightedSum + fixWord'(product >>> fracBits); // wraps modulo 2^16.
		end
	end

	// --------------------------------------------------
	// three register stages
	// --------------------------------------------------
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			actReg <= '0;
			sumReg <= '0;
			result <= '0;
		end
		else
		begin
			actReg <= act[0:fanIn-1]; // lanes past fanIn are dropped here.
			sumReg <= weightedSum;
			if (sumReg[15])
			begin
				result <= '0; // relu clamps negative sums.
			end
			else
			begin
				result <= sumReg;
			end
		end
	end

endmodule

// ==== logic/denseLayer.sv ====
`timescale 1ns/1ps

module denseLayer #(
	parameter bit isOutput = 1'b0
) (
	input logic clk,
	input logic reset,
	input mlpPkg::fanInVec act,
	output mlpPkg::hiddenVec result
);
	import mlpPkg::*;

	for (genvar g = 0; g < numHidden; g++)
	begin : gNode
		if (!isOutput)
		begin : gHidden
			neuronNode #(
				.fanIn(numInputs)
			) uNode (
				.clk(clk),
				.reset(reset),
				.act(act),
				.weights(hiddenWeights[g]),
				.bias(hiddenBias[g]),
				.result(result[g])
			);
		end
		else if (g < numOutputs)
		begin : gOut
			neuronNode #(
				.fanIn(numHidden)
			) uNode (
				.clk(clk),
				.reset(reset),
				.act(act),
				.weights({outWeights[g], {(maxFanIn - numHidden){fixWord'(0)}}}),
				.bias(outBias[g]),
				.result(result[g])
			);
		end
		else
		begin : gUnused
			assign result[g] = '0; // no neuron behind this lane.
		end
	end

endmodule

// ==== logic/inferenceControl.sv ====
`timescale 1ns/1ps

module inferenceControl (
	input logic clk,
	input logic reset,
	input logic startReq,
	output logic busy,
	output logic done
);
	import mlpPkg::*;

	ctrlState state;
	logic [$clog2(netLatency)-1:0] cycleCount;

	// --------------------------------------------------
	// state machine
	// --------------------------------------------------
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= idle;
			cycleCount <= '0;
		end
		else
		begin
			case (state)
				idle, finished:
				begin
					if (startReq)
					begin
						state <= running;
						cycleCount <= '0;
					end
				end
				running:
				begin
					if (int'(cycleCount) == netLatency - 1)
					begin
						state <= finished; // pipeline now holds the current inputs.
					end
					else
					begin
						cycleCount <= cycleCount + 1'b1;
					end
				end
				default:
				begin
					state <= idle;
				end
			endcase
		end
	end

	assign busy = (state == running);
	assign done = (state == finished); // held until the next start.

endmodule

// ==== logic/apbRegFile.sv ====
`timescale 1ns/1ps

module apbRegFile (
	input logic clk,
	input logic reset,
	input mlpPkg::apbReq req,
	output mlpPkg::apbRsp rsp,
	input logic busy,
	input logic done,
	input mlpPkg::outputVec netResult,
	output mlpPkg::inputVec netInput,
	output logic startReq
);
	import mlpPkg::*;

	outputVec resultReg;
	logic access;
	logic aligned;
	logic [3:0] wordIndex;
	logic [1:0] outIndex;
	logic isInput;
	logic isCtrl;
	logic isStatus;
	logic isOutput;
	logic mapped;
	logic writeError;
	logic wrEnable;
	fixWord inWord;
	fixWord outWord;

	// --------------------------------------------------
	// address decode
	// --------------------------------------------------
	assign access = req.psel && req.penable; // zero wait states, so this is the last cycle.
	assign aligned = (req.paddr[1:0] == 2'b00);
	assign wordIndex = req.paddr[5:2];
	assign outIndex = req.paddr[3:2];

	assign isInput = aligned && (req.paddr[7:6] == addrInputBase[7:6])
		&& (wordIndex < 4'(numInputs));
	assign isCtrl = (req.paddr == addrCtrl);
	assign isStatus = (req.paddr == addrStatus);
	assign isOutput = aligned && (req.paddr[7:4] == addrOutputBase[7:4]);
	assign mapped = isInput || isCtrl || isStatus || isOutput;

	// status and results are read only, inputs and control are locked while busy.
	assign writeError = req.pwrite && ((busy && (isInput || isCtrl)) || isStatus || isOutput);
	assign wrEnable = access && req.pwrite && mapped && !writeError;

	// --------------------------------------------------
	// registers
	// --------------------------------------------------
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			netInput <= '0;
			resultReg <= '0;
			startReq <= 1'b0;
		end
		else
		begin
			if (wrEnable && isInput)
			begin
				netInput[wordIndex] <= fixWord'(req.pwdata[15:0]);
			end
			startReq <= wrEnable && isCtrl && req.pwdata[0]; // one cycle pulse.
			if (busy)
			begin
				resultReg <= netResult; // the last load lands on the edge done rises.
			end
		end
	end

	// --------------------------------------------------
	// read data and response
	// --------------------------------------------------
	assign inWord = netInput[wordIndex];
	assign outWord = resultReg[outIndex];

	always_comb
	begin
		rsp.prdata = '0;
		if (isInput)
		begin
			rsp.prdata = {{16{inWord[15]}}, inWord};
		end
		else if (isStatus)
		begin
			rsp.prdata = {30'b0, done, busy};
		end
		else if (isOutput)
		begin
			rsp.prdata = {{16{outWord[15]}}, outWord};
		end
		rsp.pready = 1'b1;
		rsp.pslverr = access && (!mapped || writeError);
	end

endmodule

// ==== logic/mlpAccel.sv ====
`timescale 1ns/1ps

module mlpAccel (
	input logic clk,
	input logic reset,
	input mlpPkg::apbReq req,
	output mlpPkg::apbRsp rsp
);
	import mlpPkg::*;

	inputVec netInput;
	hiddenVec hiddenAct;
	hiddenVec outLanes; // only the first numOutputs lanes carry results.
	logic startReq;
	logic busy;
	logic done;

	apbRegFile uRegs (
		.clk(clk),
		.reset(reset),
		.req(req),
		.rsp(rsp),
		.busy(busy),
		.done(done),
		.netResult(outLanes[0:numOutputs-1]),
		.netInput(netInput),
		.startReq(startReq)
	);

	inferenceControl uCtrl (
		.clk(clk),
		.reset(reset),
		.startReq(startReq),
		.busy(busy),
		.done(done)
	);

	// --------------------------------------------------
	// datapath
	// --------------------------------------------------
	denseLayer #(.isOutput(1'b0)) uHidden (
		.clk(clk),
		.reset(reset),
		.act(netInput),
		.result(hiddenAct)
	);

	denseLayer #(.isOutput(1'b1)) uOutput (
		.clk(clk),
		.reset(reset),
		.act({hiddenAct, {(maxFanIn - numHidden){fixWord'(0)}}}),
		.result(outLanes)
	);

endmodule

// ==== include/mlpTbModel.svh ====
`ifndef MLP_TB_MODEL_SVH
`define MLP_TB_MODEL_SVH

// --------------------------------------------------
// stimulus
// --------------------------------------------------
function automatic logic [31:0] xorshiftNext(logic [31:0] s);
	logic [31:0] x;
	x = s;
	x = x ^ (x << 13);
	x = x ^ (x >> 17);
	x = x ^ (x << 5);
	return x;
endfunction

// maps a random word onto -4.0 to +4.0 in Q8.8.
function automatic mlpPkg::fixWord randomInput(logic [31:0] r);
	return mlpPkg::fixWord'(int'(r % 32'd2049) - 1024);
endfunction

// --------------------------------------------------
// reference model
// --------------------------------------------------
function automatic mlpPkg::fixWord modelNeuron(mlpPkg::fanInVec act,
		mlpPkg::fanInVec weights, mlpPkg::fixWord bias, int fanIn);
	logic signed [31:0] product;
	mlpPkg::fixWord sum;
	sum = bias;
	for (int i = 0; i < fanIn; i++)
	begin
		product = $signed(act[i]) * $signed(weights[i]);
		sum = sum + mlpPkg::fixWord'(product >>> mlpPkg::fracBits); // wraps like the RTL.
	end
	return sum[15] ? mlpPkg::fixWord'(0) : sum;
endfunction

function automatic mlpPkg::outputVec modelNetwork(mlpPkg::inputVec x);
	mlpPkg::hiddenVec h;
	mlpPkg::outputVec y;
	mlpPkg::fanInVec padded;
	for (int j = 0; j < mlpPkg::numHidden; j++)
	begin
		h[j] = modelNeuron(x, mlpPkg::hiddenWeights[j], mlpPkg::hiddenBias[j],
			mlpPkg::numInputs);
	end
	padded = {h, {(mlpPkg::maxFanIn - mlpPkg::numHidden){mlpPkg::fixWord'(0)}}};
	for (int j = 0; j < mlpPkg::numOutputs; j++)
	begin
		y[j] = modelNeuron(padded,
			{mlpPkg::outWeights[j], {(mlpPkg::maxFanIn - mlpPkg::numHidden){mlpPkg::fixWord'(0)}}},
			mlpPkg::outBias[j], mlpPkg::numHidden);
	end
	return y;
endfunction

`endif

// ==== dv/mlpAccelTb.sv ====
`timescale 1ns/1ps

module mlpAccelTb;
	import mlpPkg::*;

	`include "mlpTbModel.svh"

	localparam int pollTimeout = 50; // cycles allowed per polling wait.

	logic clk = 1'b0;
	logic reset = 1'b1;
	apbReq req = '0;
	apbRsp rsp;
	logic [31:0] rngState = 32'd72;
	inputVec curInput = '0;
	int errorCount = 0;
	int testErrors = 0;
	int testsFailed = 0;

	mlpAccel u_dut (
		.clk(clk),
		.reset(reset),
		.req(req),
		.rsp(rsp)
	);

	always #10 clk = ~clk;

	// --------------------------------------------------
	// apb driver
	// --------------------------------------------------
	task automatic apbWrite(input apbAddr addr, input apbData data, output logic err);
		req = '{psel: 1'b1, penable: 1'b0, pwrite: 1'b1, paddr: addr, pwdata: data};
		@(posedge clk);
		#1;
		req.penable = 1'b1;
		@(negedge clk);
		err = rsp.pslverr; // sampled in the middle of the access cycle.
		checkFlag("pready on write", rsp.pready, 1'b1);
		@(posedge clk);
		#1;
		req = '0;
	endtask

	task automatic apbRead(input apbAddr addr, output apbData data, output logic err);
		req = '{psel: 1'b1, penable: 1'b0, pwrite: 1'b0, paddr: addr, pwdata: '0};
		@(posedge clk);
		#1;
		req.penable = 1'b1;
		@(negedge clk);
		data = rsp.prdata;
		err = rsp.pslverr;
		checkFlag("pready on read", rsp.pready, 1'b1);
		@(posedge clk);
		#1;
		req = '0;
	endtask

	function automatic logic [31:0] drawRandom();
		rngState = xorshiftNext(rngState);
		return rngState;
	endfunction

	function automatic apbData signExtend(fixWord w);
		return {{16{w[15]}}, w};
	endfunction

	// --------------------------------------------------
	// compare tasks
	// --------------------------------------------------
	task automatic checkWord(input string name, input fixWord got, input fixWord expected);
		if (got !== expected)
		begin
			$display("ERROR %0t ns: %s is %0d, expected %0d", $time, name, got, expected);
			errorCount++;
		end
	endtask

	task automatic checkData(input string name, input apbData got, input apbData expected);
		if (got !== expected)
		begin
			$display("ERROR %0t ns: %s is %h, expected %h", $time, name, got, expected);
			errorCount++;
		end
	endtask

	task automatic checkFlag(input string name, input logic got, input logic expected);
		if (got !== expected)
		begin
			$display("ERROR %0t ns: %s is %b, expected %b", $time, name, got, expected);
			errorCount++;
		end
	endtask

	task automatic endTest(input string name);
		$display("test %s finished with %0d errors", name, errorCount - testErrors);
		if (errorCount != testErrors)
		begin
			testsFailed++;
		end
		testErrors = errorCount;
	endtask

	// --------------------------------------------------
	// sequences
	// --------------------------------------------------
	task automatic checkStatus(input string when, input logic busyExp, input logic doneExp);
		apbData d;
		logic err;
		apbRead(addrStatus, d, err);
		checkFlag({"pslverr on status read ", when}, err, 1'b0);
		checkFlag({"busy ", when}, d[0], busyExp);
		checkFlag({"done ", when}, d[1], doneExp);
	endtask

	task automatic waitDone();
		apbData d;
		logic err;
		int cycles;
		d = '0;
		cycles = 0;
		while (!d[1] && cycles < pollTimeout)
		begin
			apbRead(addrStatus, d, err);
			cycles += 2; // a status read takes two cycles.
		end
		if (!d[1])
		begin
			$display("timeout: done was not seen within %0d cycles at %0t ns", pollTimeout, $time);
			errorCount++;
		end
	endtask

	task automatic loadInputs();
		logic err;
		for (int k = 0; k < numInputs; k++)
		begin
			apbWrite(apbAddr'(addrInputBase + 4 * k), signExtend(curInput[k]), err);
			checkFlag($sformatf("pslverr on input[%0d] write", k), err, 1'b0);
		end
	endtask

	task automatic startRun();
		logic err;
		apbWrite(addrCtrl, 32'h1, err);
		checkFlag("pslverr on start", err, 1'b0);
	endtask

	task automatic checkResults(input outputVec expected);
		apbData d;
		logic err;
		for (int j = 0; j < numOutputs; j++)
		begin
			apbRead(apbAddr'(addrOutputBase + 4 * j), d, err);
			checkFlag($sformatf("pslverr on result[%0d] read", j), err, 1'b0);
			checkWord($sformatf("result[%0d]", j), fixWord'(d[15:0]), expected[j]);
			checkData($sformatf("result[%0d] read data", j), d, signExtend(expected[j]));
		end
	endtask

	// --------------------------------------------------
	// test sequence
	// --------------------------------------------------
	initial
	begin
		apbData d;
		apbData written [numInputs];
		logic err;
		outputVec expected;
		fixWord kept;
		apbAddr badAddr [4];
		badAddr = '{8'h3c, 8'h48, 8'h06, 8'h60};
		repeat (3) @(posedge clk);
		#1;
		reset = 1'b0;

		checkStatus("after reset", 1'b0, 1'b0);
		checkResults('0);
		endTest("reset state");

		for (int k = 0; k < numInputs; k++)
		begin
			written[k] = drawRandom();
			apbWrite(apbAddr'(addrInputBase + 4 * k), written[k], err);
			checkFlag($sformatf("pslverr on input[%0d] write", k), err, 1'b0);
		end
		for (int k = 0; k < numInputs; k++)
		begin
			apbRead(apbAddr'(addrInputBase + 4 * k), d, err);
			checkData($sformatf("input[%0d] read data", k), d, signExtend(written[k][15:0]));
		end
		endTest("input readback");

		repeat (40)
		begin
			for (int k = 0; k < numInputs; k++)
			begin
				curInput[k] = randomInput(drawRandom());
			end
			loadInputs();
			startRun();
			waitDone();
			checkResults(modelNetwork(curInput));
		end
		endTest("random inferences");

		// the start access cycle ends on edge 0 and done rises on edge 7.
		expected = modelNetwork(curInput);
		startRun();
		repeat (5) @(posedge clk);
		#1;
		checkStatus("in read begun one cycle early", 1'b1, 1'b0);
		waitDone();
		startRun();
		repeat (6) @(posedge clk);
		#1;
		checkStatus("in read begun at latency", 1'b0, 1'b1);
		checkResults(expected);
		endTest("done timing");

		for (int k = 0; k < numInputs; k++)
		begin
			curInput[k] = randomInput(drawRandom());
		end
		loadInputs();
		expected = modelNetwork(curInput);
		kept = curInput[3];
		startRun();
		apbWrite(apbAddr'(addrInputBase + 12), signExtend(~kept), err);
		checkFlag("pslverr on input write while busy", err, 1'b1);
		apbWrite(addrCtrl, 32'h1, err);
		checkFlag("pslverr on start while busy", err, 1'b1);
		foreach (badAddr[i])
		begin
			apbRead(badAddr[i], d, err);
			checkFlag($sformatf("pslverr on read of 0x%h", badAddr[i]), err, 1'b1);
		end
		apbWrite(8'h60, 32'h1, err);
		checkFlag("pslverr on unmapped write", err, 1'b1);
		apbWrite(addrOutputBase, 32'h1234, err);
		checkFlag("pslverr on result write", err, 1'b1);
		apbWrite(addrStatus, 32'h3, err);
		checkFlag("pslverr on status write", err, 1'b1);
		waitDone();
		apbRead(apbAddr'(addrInputBase + 12), d, err);
		checkData("input[3] after refused write", d, signExtend(kept));
		checkResults(expected);
		endTest("error responses");

		startRun();
		checkStatus("right after restart", 1'b1, 1'b0);
		waitDone();
		checkResults(expected);
		endTest("repeated start");

		$display("summary: 6 tests, %0d failed, %0d errors", testsFailed, errorCount);
		if (errorCount == 0)
		begin
			$display("All tests passed!");
		end
		else
		begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

// ==== project.f ====
+incdir+include
logic/mlpPkg.sv
logic/neuronNode.sv
logic/denseLayer.sv
logic/inferenceControl.sv
logic/apbRegFile.sv
logic/mlpAccel.sv
dv/mlpAccelTb.sv

// ==== Makefile ====
# Verilator build and run for the MLP accelerator testbench.

VERILATOR ?= verilator
TOP ?= mlpAccelTb
FILELIST ?= project.f
BUILD_DIR ?= obj_dir
VERILATOR_FLAGS ?= --binary --timing --timescale 1ns/1ps -j 0
PASS_TEXT ?= All tests passed!

SOURCES := $(filter-out +%,$(shell cat $(FILELIST)))
HEADERS := $(wildcard include/*.svh)
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM_BIN)

# rebuilt only when a source, header or the file list changes
$(SIM_BIN): $(FILELIST) $(SOURCES) $(HEADERS)
	$(VERILATOR) $(VERILATOR_FLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

# the run fails unless the pass message shows up in the output
run: $(SIM_BIN)
	@out="$$($(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
